// File: design/stepperPkg.sv
package stepperPkg;

    localparam int JOINT_IDX_W = 2;

    // Step types
    localparam int TYPE_WAVE = 0;
    localparam int TYPE_FULL = 1;
    localparam int TYPE_HALF = 2;

    typedef enum logic [1:0] {
        OP_FREQ    = 2'd0,
        OP_ENABLE  = 2'd1,
        OP_READPOS = 2'd2,
        OP_NOP     = 2'd3
    } cmdOpT;

    typedef struct packed {
        cmdOpT                   op;
        logic [JOINT_IDX_W-1:0]  joint;
        logic signed [31:0]      value;
    } jointCmdT;

    typedef struct packed {
        logic [JOINT_IDX_W-1:0]  joint;
        logic signed [31:0]      pos;
    } posReportT;

    // Coil order per entry is {b2, b1, a2, a1}
    localparam logic [3:0] SEQ_HALF [0:7] = '{4'b1000, 4'b1100, 4'b0100, 4'b0110,
                                              4'b0010, 4'b0011, 4'b0001, 4'b1001};
    localparam logic [3:0] SEQ_FULL [0:7] = '{4'b1001, 4'b1001, 4'b1100, 4'b1100,
                                              4'b0110, 4'b0110, 4'b0011, 4'b0011};

endpackage

// File: design/creditFifo.sv
module creditFifo #(
    parameter int DEPTH = 8,
    parameter type payloadT = logic [31:0]
) (
    input  logic    clk,
    input  logic    rst,
    input  logic    push,
    input  payloadT pushData,
    input  logic    pop,
    output payloadT popData,
    output logic    empty,
    output logic    full,
    output logic    credit
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payloadT            mem [DEPTH];
    logic [PTR_W-1:0]   wrPtr;
    logic [PTR_W-1:0]   rdPtr;
    logic [CNT_W-1:0]   count;
    logic               doPush;
    logic               doPop;

    assign empty  = (count == '0);
    assign full   = (count == CNT_W'(DEPTH));
    assign doPush = push && !full;     // Overflow is dropped
    assign doPop  = pop && !empty;
    assign credit = doPop;             // One credit back per entry leaving

    assign popData = mem[rdPtr];

    always_ff @(posedge clk) begin
        if (doPush) begin
            mem[wrPtr] <= pushData;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (doPush) begin
                wrPtr <= (wrPtr == PTR_W'(DEPTH - 1)) ? '0 : wrPtr + 1'b1;
            end
            if (doPop) begin
                rdPtr <= (rdPtr == PTR_W'(DEPTH - 1)) ? '0 : rdPtr + 1'b1;
            end
            case ({doPush, doPop})
                2'b10: begin
                    count <= count + 1'b1;
                end
                2'b01: begin
                    count <= count - 1'b1;
                end
                default: begin
                    count <= count;
                end
            endcase
        end
    end

endmodule

// File: design/jointRegs.sv
module jointRegs import stepperPkg::*; #(
    parameter int NUM_JOINTS = 4
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         cmdValid,
    input  cmdOpT                        cmdOp,
    input  logic [JOINT_IDX_W-1:0]       cmdJoint,
    input  logic signed [31:0]           cmdValue,
    output logic signed [31:0]           freqCmd [NUM_JOINTS],
    output logic [NUM_JOINTS-1:0]        jointEnable,
    output logic                         snapReq,
    output logic [JOINT_IDX_W-1:0]       snapJoint
);

    logic jointInRange;
    logic doFreq;
    logic doEnable;
    logic doRead;

    // Commands to joints that are not built are discarded
    assign jointInRange = (int'(cmdJoint) < NUM_JOINTS);

    always_comb begin
        doFreq   = 1'b0;
        doEnable = 1'b0;
        doRead   = 1'b0;
        if (cmdValid && jointInRange) begin
            case (cmdOp)
                OP_FREQ: begin
                    doFreq = 1'b1;
                end
                OP_ENABLE: begin
                    doEnable = 1'b1;
                end
                OP_READPOS: begin
                    doRead = 1'b1;
                end
                default: begin
                    doFreq = 1'b0;     // OP_NOP
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int j = 0; j < NUM_JOINTS; j++) begin
                freqCmd[j] <= '0;
            end
            jointEnable <= '0;
            snapReq     <= 1'b0;
        end else begin
            if (doFreq) begin
                freqCmd[cmdJoint] <= cmdValue;
            end
            if (doEnable) begin
                jointEnable[cmdJoint] <= cmdValue[0];
            end
            snapReq <= doRead;         // Single cycle request
        end
    end

    // Joint index of the pending snapshot
    always_ff @(posedge clk) begin
        if (doRead) begin
            snapJoint <= cmdJoint;
        end
    end

endmodule

// File: design/jointStepper4pin.sv
module jointStepper4pin import stepperPkg::*; #(
    parameter int STEPTYPE = TYPE_HALF
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               jointEnable,
    input  logic signed [31:0] jointFreqCmd,
    output logic               a1,
    output logic               a2,
    output logic               b1,
    output logic               b2,
    output logic signed [31:0] position
);

    // Wave and full drive skip every other table entry
    localparam logic [2:0] PHASE_STRIDE = (STEPTYPE == TYPE_HALF) ? 3'd1 : 3'd2;

    logic        stepToggle;
    logic        dir;
    logic [31:0] divCount;
    logic [31:0] freqAbs;
    logic [2:0]  phaseIdx;
    logic [3:0]  pattern;
    logic        running;
    logic        advance;

    assign dir     = (jointFreqCmd > 0);
    assign running = (jointFreqCmd != 0) && jointEnable;
    assign advance = running && (divCount >= freqAbs) && stepToggle;

    always_comb begin
        if (STEPTYPE == TYPE_FULL) begin
            pattern = SEQ_FULL[phaseIdx];
        end else begin
            pattern = SEQ_HALF[phaseIdx];
        end
    end

    // Coils are released while disabled
    assign a1 = jointEnable && pattern[0];
    assign a2 = jointEnable && pattern[1];
    assign b1 = jointEnable && pattern[2];
    assign b2 = jointEnable && pattern[3];

    always_ff @(posedge clk) begin
        if (rst) begin
            freqAbs <= '0;
        end else if (dir) begin
            freqAbs <= jointFreqCmd;
        end else begin
            freqAbs <= -jointFreqCmd;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            divCount   <= '0;
            stepToggle <= 1'b0;
        end else begin
            divCount <= divCount + 1'b1;
            if (running && (divCount >= freqAbs)) begin
                stepToggle <= ~stepToggle;
                divCount   <= '0;
            end
        end
    end

    // Phase moves on the falling half of the step toggle
    always_ff @(posedge clk) begin
        if (rst) begin
            phaseIdx <= '0;
            position <= '0;
        end else if (advance) begin
            if (dir) begin
                phaseIdx <= phaseIdx + PHASE_STRIDE;
                position <= position + 32'sd1;
            end else begin
                phaseIdx <= phaseIdx - PHASE_STRIDE;
                position <= position - 32'sd1;
            end
        end
    end

endmodule

// File: design/stepperCtrl.sv
module stepperCtrl import stepperPkg::*; #(
    parameter int NUM_JOINTS = 4,
    parameter int CMD_DEPTH  = 8,
    parameter int REP_DEPTH  = 4,
    parameter int STEPTYPE   = TYPE_HALF
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    cmdValid,
    input  cmdOpT                   cmdOp,
    input  logic [JOINT_IDX_W-1:0]  cmdJoint,
    input  logic signed [31:0]      cmdValue,
    output logic                    cmdCredit,
    input  logic                    repCredit,
    output logic                    repValid,
    output logic [JOINT_IDX_W-1:0]  repJoint,
    output logic signed [31:0]      repPos,
    output logic [NUM_JOINTS-1:0]   coilA1,
    output logic [NUM_JOINTS-1:0]   coilA2,
    output logic [NUM_JOINTS-1:0]   coilB1,
    output logic [NUM_JOINTS-1:0]   coilB2
);

    jointCmdT                   cmdIn;
    jointCmdT                   cmdHead;
    posReportT                  snapData;
    posReportT                  repHead;
    logic                       repFull;
    logic                       repPop;
    logic                       snapReq;
    logic [JOINT_IDX_W-1:0]     snapJoint;
    logic signed [31:0]         freqCmd [NUM_JOINTS];
    logic [NUM_JOINTS-1:0]      jointEnable;
    logic signed [31:0]         position [NUM_JOINTS];
    logic [15:0]                repCreditCnt;

    assign cmdIn    = '{op: cmdOp, joint: cmdJoint, value: cmdValue};
    assign snapData = '{joint: snapJoint, pos: position[snapJoint]};

    // Hold pops while a snapshot is in flight so the report FIFO never overflows
    creditFifo #(.DEPTH(CMD_DEPTH), .payloadT(jointCmdT)) cmdFifo (
        .clk(clk), .rst(rst),
        .push(cmdValid), .pushData(cmdIn),
        .pop(!repFull && !snapReq), .popData(cmdHead),
        .empty(), .full(), .credit(cmdCredit)
    );

    jointRegs #(.NUM_JOINTS(NUM_JOINTS)) regs (
        .clk(clk), .rst(rst),
        .cmdValid(cmdCredit), .cmdOp(cmdHead.op),
        .cmdJoint(cmdHead.joint), .cmdValue(cmdHead.value),
        .freqCmd(freqCmd), .jointEnable(jointEnable),
        .snapReq(snapReq), .snapJoint(snapJoint)
    );

    for (genvar j = 0; j < NUM_JOINTS; j++) begin : gJoint
        jointStepper4pin #(.STEPTYPE(STEPTYPE)) joint (
            .clk(clk), .rst(rst),
            .jointEnable(jointEnable[j]), .jointFreqCmd(freqCmd[j]),
            .a1(coilA1[j]), .a2(coilA2[j]), .b1(coilB1[j]), .b2(coilB2[j]),
            .position(position[j])
        );
    end

    creditFifo #(.DEPTH(REP_DEPTH), .payloadT(posReportT)) repFifo (
        .clk(clk), .rst(rst),
        .push(snapReq), .pushData(snapData),
        .pop(repCreditCnt != '0), .popData(repHead),
        .empty(), .full(repFull), .credit(repPop)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            repCreditCnt <= '0;
            repValid     <= 1'b0;
        end else begin
            repCreditCnt <= repCreditCnt + 16'(repCredit) - 16'(repPop);
            repValid     <= repPop;
        end
    end

    always_ff @(posedge clk) begin
        if (repPop) begin
            repJoint <= repHead.joint;
            repPos   <= repHead.pos;
        end
    end

endmodule

// File: testbench/stepperCtrlTb.sv
module stepperCtrlTb
    import stepperPkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int    NUM_JOINTS = 4;
    localparam int    CMD_DEPTH  = 8;
    localparam int    REP_DEPTH  = 4;
    localparam int    RST_CYCLES = 5;
    localparam string INPUT_FILE = "testbench/stepperInput.txt";

    // Half step sequence with coils as {b2, b1, a2, a1}
    localparam logic [3:0] HALF_STEP [8] = '{4'b1000, 4'b1100, 4'b0100, 4'b0110,
                                             4'b0010, 4'b0011, 4'b0001, 4'b1001};

    logic                   clk;
    logic                   rst;
    logic                   cmdValid;
    cmdOpT                  cmdOp;
    logic [JOINT_IDX_W-1:0] cmdJoint;
    logic signed [31:0]     cmdValue;
    logic                   cmdCredit;
    logic                   repCredit;
    logic                   repValid;
    logic [JOINT_IDX_W-1:0] repJoint;
    logic signed [31:0]     repPos;
    logic [NUM_JOINTS-1:0]  coilA1;
    logic [NUM_JOINTS-1:0]  coilA2;
    logic [NUM_JOINTS-1:0]  coilB1;
    logic [NUM_JOINTS-1:0]  coilB2;

    int                     errors = 0;
    int                     checks = 0;
    int                     sent = 0;
    int                     returned = 0;       // cmdCredit pulses seen
    int                     cycle = 0;
    int                     limitCycles = 0;
    logic [NUM_JOINTS-1:0]  running = '0;
    int                     runStart [NUM_JOINTS];
    int                     runCycles [NUM_JOINTS];
    int                     runWord [NUM_JOINTS];
    logic signed [31:0]     lastPos [NUM_JOINTS];
    logic signed [31:0]     prevPos [NUM_JOINTS];
    int                     expJointQ [$];      // Joints of reads still unanswered
    int                     gotJointQ [$];
    logic signed [31:0]     gotPosQ [$];

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    stepperCtrl #(.NUM_JOINTS(NUM_JOINTS), .CMD_DEPTH(CMD_DEPTH), .REP_DEPTH(REP_DEPTH),
                  .STEPTYPE(TYPE_HALF)) UUT (
        .clk(clk), .rst(rst),
        .cmdValid(cmdValid), .cmdOp(cmdOp), .cmdJoint(cmdJoint), .cmdValue(cmdValue),
        .cmdCredit(cmdCredit), .repCredit(repCredit),
        .repValid(repValid), .repJoint(repJoint), .repPos(repPos),
        .coilA1(coilA1), .coilA2(coilA2), .coilB1(coilB1), .coilB2(coilB2)
    );

    always @(negedge clk) begin
        cycle++;
        if (!rst && cmdCredit) begin
            returned++;
        end
        if (!rst && repValid) begin
            gotJointQ.push_back(int'(repJoint));
            gotPosQ.push_back(repPos);
        end
    end

    function automatic logic [3:0] coilsOf(input int j);
        return {coilB2[j], coilB1[j], coilA2[j], coilA1[j]};
    endfunction

    task automatic compareValue(input string name, input longint expected, input longint actual);
        checks++;
        assert (expected == actual) else begin
            errors++;
            $display("Error: time %0t, %s expected %0d, actual %0d", $time, name, expected, actual);
        end
    endtask

    task automatic confirm(input bit ok, input string what);
        checks++;
        assert (ok) else begin
            errors++;
            $display("Failure at time %0t: %s", $time, what);
        end
    endtask

    task automatic countWorkload(output int total);
        int          fd;
        int          a;
        string       line;
        logic [63:0] kw;
        total = RST_CYCLES + 200;
        fd = $fopen(INPUT_FILE, "r");
        while (fd != 0 && $fgets(line, fd) > 0) begin
            if (line.len() < 2 || line.getc(0) == "#") begin
                continue;
            end
            a = 0;
            void'($sscanf(line, "%s %d", kw, a));
            if (kw == "WAIT") begin
                total += a;
            end else if (kw == "GRANT") begin
                total += 200 * a;
            end else begin
                total += 200;
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end
    endtask

    task automatic sendCommand(input cmdOpT op, input int joint, input int value);
        repeat ($urandom_range(3, 0)) @(posedge clk);
        @(posedge clk);
        while (sent - returned >= CMD_DEPTH) begin  // Out of credits
            @(posedge clk);
        end
        cmdValid <= 1'b1;
        cmdOp    <= op;
        cmdJoint <= JOINT_IDX_W'(joint);
        cmdValue <= value;
        sent++;
        if (op == OP_FREQ && value != 0) begin
            running[joint]  = 1'b1;
            runStart[joint] = cycle;
            runWord[joint]  = (value < 0) ? -value : value;
        end else if (op == OP_FREQ && running[joint]) begin
            running[joint]   = 1'b0;
            runCycles[joint] = cycle - runStart[joint];
        end
        @(posedge clk);
        cmdValid <= 1'b0;
    endtask

    task automatic settleCommands();
        while (returned != sent) begin
            @(posedge clk);
        end
        repeat (3) @(posedge clk);
        @(negedge clk);
    endtask

    task automatic takeReport();
        int                 joint;
        logic signed [31:0] pos;
        joint = gotJointQ.pop_front();
        pos   = gotPosQ.pop_front();
        if (expJointQ.size() == 0) begin
            confirm(1'b0, "a report arrived with no read request pending");
        end else begin
            compareValue("repJoint", expJointQ.pop_front(), joint);
            prevPos[joint] = lastPos[joint];
            lastPos[joint] = pos;
        end
    endtask

    task automatic grantReports(input int count);
        int waited;
        repeat (count) begin
            repeat ($urandom_range(8, 1)) @(posedge clk);
            confirm(gotJointQ.size() == 0, "a report appeared with no report credit granted");
            repCredit <= 1'b1;
            @(posedge clk);
            repCredit <= 1'b0;
            waited = 0;
            while (gotJointQ.size() == 0 && waited < 100) begin
                @(posedge clk);
                waited++;
            end
            confirm(gotJointQ.size() == 1, "a granted credit did not give exactly one report");
            if (gotJointQ.size() != 0) begin
                takeReport();
            end
        end
    endtask

    task automatic runCheck(input logic [63:0] kind, input int j);
        int    moved;
        int    bound;
        string coilName;
        moved    = lastPos[j] - prevPos[j];
        bound    = runCycles[j] / (2 * (runWord[j] + 1)) + 1;  // Two toggles per step
        coilName = $sformatf("coils[%0d]", j);
        if (kind == "SAME") begin
            compareValue($sformatf("repPos[%0d]", j), prevPos[j], lastPos[j]);
        end else if (kind == "UP" || kind == "DOWN") begin
            if (kind == "DOWN") begin
                moved = -moved;
            end
            confirm(moved > 0, $sformatf("joint %0d did not move the commanded way", j));
            confirm(moved <= bound,
                    $sformatf("joint %0d moved %0d steps, over the bound %0d", j, moved, bound));
        end else if (kind == "COIL") begin
            settleCommands();
            compareValue(coilName, HALF_STEP[lastPos[j][2:0]], coilsOf(j));
        end else if (kind == "OFF") begin
            settleCommands();
            compareValue(coilName, 0, coilsOf(j));
        end else if (kind == "NOREP") begin
            confirm(gotJointQ.size() == 0, "a report appeared with no report credit granted");
        end else begin
            confirm(1'b0, "the input file holds an unknown check");
        end
    endtask

    initial begin
        int          fd;
        int          a;
        int          b;
        string       line;
        logic [63:0] kw;
        logic [63:0] kind;
        void'($urandom(32'ha09e1ec9));
        rst       = 1'b1;
        cmdValid  = 1'b0;
        cmdOp     = OP_NOP;
        cmdJoint  = '0;
        cmdValue  = '0;
        repCredit = 1'b0;
        for (int j = 0; j < NUM_JOINTS; j++) begin
            lastPos[j] = '0;
            prevPos[j] = '0;
        end
        countWorkload(limitCycles);
        fork
            begin
                repeat (limitCycles) @(posedge clk);
                $display("Timeout, the run did not finish within %0d cycles", limitCycles);
                $display("tests failed");
                $finish;
            end
        join_none

        repeat (RST_CYCLES) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        compareValue("coilA1", 0, coilA1);
        compareValue("coilA2", 0, coilA2);
        compareValue("coilB1", 0, coilB1);
        compareValue("coilB2", 0, coilB2);
        compareValue("repValid", 0, repValid);
        compareValue("cmdCredit", 0, cmdCredit);

        fd = $fopen(INPUT_FILE, "r");
        confirm(fd != 0, "the input file could not be opened");
        while (fd != 0 && $fgets(line, fd) > 0) begin
            if (line.len() < 2 || line.getc(0) == "#") begin
                continue;
            end
            a = 0;
            b = 0;
            void'($sscanf(line, "%s %d %d", kw, a, b));
            if (kw == "CHECK") begin
                void'($sscanf(line, "%s %s %d", kw, kind, a));
                runCheck(kind, a);
            end else if (kw == "FREQ") begin
                sendCommand(OP_FREQ, a, b);
            end else if (kw == "ENABLE") begin
                sendCommand(OP_ENABLE, a, b);
            end else if (kw == "NOP") begin
                sendCommand(OP_NOP, a, b);
            end else if (kw == "READ") begin
                expJointQ.push_back(a);
                sendCommand(OP_READPOS, a, 0);
            end else if (kw == "GRANT") begin
                grantReports(a);
            end else if (kw == "WAIT") begin
                repeat (a) @(posedge clk);
            end else begin
                confirm(1'b0, "the input file holds an unknown keyword");
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end

        settleCommands();
        repeat (20) @(posedge clk);
        compareValue("cmdCredit pulses", sent, returned);
        confirm(expJointQ.size() == 0 && gotJointQ.size() == 0,
                "read requests and reports do not pair up");
        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// File: stepperCtrl.f
design/stepperPkg.sv
design/creditFifo.sv
design/jointRegs.sv
design/jointStepper4pin.sv
design/stepperCtrl.sv
testbench/stepperCtrlTb.sv

// File: runSim.sh
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --assert --timescale 1ns/1ps -Wno-fatal \
    --top-module stepperCtrlTb -f stepperCtrl.f -o stepperSim \
    && ./obj_dir/stepperSim | tee /dev/stderr | grep -q "all tests passed" \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

// File: testbench/stepperInput.txt
# Columns: keyword, joint or count, value
# FREQ/ENABLE/NOP joint value, READ joint, GRANT credits, WAIT cycles, CHECK kind joint
ENABLE 1 1
ENABLE 3 1
FREQ 2 7
WAIT 20
CHECK COIL 1
CHECK COIL 3
CHECK OFF 2
READ 1
READ 2
READ 3
GRANT 3
WAIT 300
READ 1
READ 2
GRANT 2
CHECK SAME 1
CHECK SAME 2
# Joint 0 runs forward, then in reverse
ENABLE 0 1
FREQ 0 5
WAIT 400
FREQ 0 0
READ 0
GRANT 1
CHECK UP 0
FREQ 0 -3
WAIT 300
FREQ 0 0
READ 0
GRANT 1
CHECK DOWN 0
ENABLE 0 0
CHECK OFF 0
ENABLE 0 1
CHECK COIL 0
READ 3
GRANT 1
CHECK SAME 3
CHECK COIL 3
NOP 2 99
CHECK OFF 2
# Five reads with no report credit, the last one waits in the command FIFO
READ 3
READ 0
READ 1
READ 3
READ 2
WAIT 60
CHECK NOREP 0
GRANT 5
CHECK SAME 3
CHECK SAME 0
CHECK COIL 1
